/* testbench/skeinTests.txt */
// per vector 26 words of 64 bits, word 0 first, four to a line
// message w0-w7, key w0-w7, tweak t0 t1, expected chaining output w0-w7
// all-zero message, key and tweak
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 BC2560EFC6BBA2B1 E3361F162238EB40
FB8631EE0ABBD175 7B9479D4C5479ED1 CFF0356E58F8C27B B1B7B08430F0E7F7
E9A380A56139ABF1 BE7B6D4AA11EB47E
// config block for a 512 bit output, gives the Skein-512-512 IV
0000000133414853 0000000000000200 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000020 C400000000000000 4903ADFF749C51CE 0D95DE399746DF03
8FD1934127C79BCE 9A255629FF352CB1 5DB62599DF6CA7B0 EABE394CA9D5C3F4
991112C71A75B523 AE18A40B660FCC33
// config block for a 256 bit output, gives the Skein-512-256 IV
0000000133414853 0000000000000100 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000020 C400000000000000 CCD044A12FDB3E13 E83590301A79A9EB
55AEA0614F816E6F 2A2767A4AE9B94DB EC06025E74DD7683 E7A436CDC4746251
C36FBAF9393AD185 3EEDBA1833EDFC13
// config block for a 384 bit output, gives the Skein-512-384 IV
0000000133414853 0000000000000180 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000020 C400000000000000 A3F6C6BF3A75EF5F B0FEF9CCFD84FAA4
9D77DD663D770CFE D798CBF3B468FDDA 1BC4A6668A0E4465 7ED7D434E5807407
548FC1ACD4EC44D6 266E17546AA18FF8

/* files.f */
+incdir+include
hw/skeinPkg.sv
hw/threefishMixPair.sv
hw/threefishStage.sv
hw/threefishKeyExpand.sv
hw/ubiFinish.sv
hw/skein512Block.sv
testbench/tbSkein.sv

/* Makefile */
SIM = obj_dir/VtbSkein

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f files.f --top-module tbSkein -Mdir obj_dir

run: build
	out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only hw/skeinPkg.sv hw/threefishMixPair.sv hw/threefishStage.sv \
		hw/threefishKeyExpand.sv hw/ubiFinish.sv hw/skein512Block.sv \
		--top-module skein512Block

clean:
	rm -rf obj_dir

/* include/tbSkeinTasks.svh */
// helpers included into the tbSkein module body
// they use the module's clk, error counters and vector memory
`ifndef TB_SKEIN_TASKS_SVH
`define TB_SKEIN_TASKS_SVH

task automatic checkValue(input string what, input logic [511:0] got,
	input logic [511:0] expected);
	checks++;
	if (got !== expected) begin
		errors++;
		$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
	end
endtask

// Galois form, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrStep(input logic [31:0] s);
	logic [31:0] r;
	r = s >> 1;
	if (s[0]) begin
		r = r ^ 32'h80200003;
	end
	return r;
endfunction

task automatic loadVectors();
	$readmemh("testbench/skeinTests.txt", vecMem);
endtask

// word layout per vector: msg 0-7, key 8-15, tweak 16-17, expected 18-25
task automatic vectorAt(input int index, output skeinPkg::blockInT blk,
	output skeinPkg::stateT expected);
	int base;
	base = index * wordsPerVector;
	for (int w = 0; w < 8; w++) begin
		blk.msg[w] = vecMem[base + w];
		blk.key[w] = vecMem[base + 8 + w];
		expected[w] = vecMem[base + 18 + w];
	end
	blk.tweak[0] = vecMem[base + 16];
	blk.tweak[1] = vecMem[base + 17];
endtask

`endif

/* testbench/tbSkein.sv */
`timescale 1ns/1ps
// testbench for skein512Block, vectors and expected values from testbench/skeinTests.txt
// run from the project root so the vector file path resolves
// input gaps and output stalls come from two LFSR streams
module tbSkein;

	localparam int clkPeriod = 20;
	localparam int numVectors = 4;
	localparam int wordsPerVector = 26;
	localparam int expectLatency = 56;
	localparam int waitLimit = 1000;

	logic clk;
	logic rst;
	logic inValid;
	logic inReady;
	skeinPkg::blockInT inData;
	logic outValid;
	logic outReady;
	skeinPkg::stateT outData;

	logic [63:0] vecMem [0:numVectors*wordsPerVector-1];
	skeinPkg::stateT expectQ [$];
	longint acceptTimes [$];
	logic [31:0] drvLfsr;
	logic [31:0] rcvLfsr;
	int errors;
	int checks;

	`include "tbSkeinTasks.svh"

	skein512Block u_dut (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inReady(inReady),
		.inData(inData),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outData)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic abortOnTimeout(input string what);
		$display("timeout while waiting for %s at %0t", what, $time);
		$display("checks %0d, errors %0d", checks, errors);
		$display("Test failed");
		$finish;
	endtask

	function automatic bit nextDrvBit();
		bit b;
		b = drvLfsr[0];
		drvLfsr = lfsrStep(drvLfsr);
		return b;
	endfunction

	function automatic bit nextRcvBit();
		bit b;
		b = rcvLfsr[0];
		rcvLfsr = lfsrStep(rcvLfsr);
		return b;
	endfunction

	task automatic driveVectors(input int total, input bit gaps);
		skeinPkg::blockInT blk;
		skeinPkg::stateT expected;
		int waited;
		int gapLen;
		@(posedge clk);
		for (int v = 0; v < total; v++) begin
			gapLen = 0;
			// a gap cycle needs two set bits in a row
			while (gaps && gapLen < 16 && nextDrvBit() && nextDrvBit()) begin
				inValid <= 1'b0;
				@(posedge clk);
				gapLen++;
			end
			vectorAt(v % numVectors, blk, expected);
			inValid <= 1'b1;
			inData <= blk;
			waited = 0;
			do begin
				@(posedge clk);
				waited++;
				if (waited > waitLimit) begin
					abortOnTimeout("input acceptance");
				end
			end while (!inReady);
			expectQ.push_back(expected);
			acceptTimes.push_back($time);
		end
		inValid <= 1'b0;
	endtask

	task automatic collectResults(input int total, input bit stall, input bit backToBack,
		input bit checkLatency);
		skeinPkg::stateT heldData;
		skeinPkg::stateT expected;
		longint lastRx;
		longint accTime;
		int got;
		int idle;
		bit held;
		got = 0;
		idle = 0;
		held = 1'b0;
		lastRx = 0;
		while (got < total) begin
			@(posedge clk);
			if (held) begin
				checkValue("outValid while held", 512'(outValid), 1);
				checkValue("outData while held", outData, heldData);
			end
			held = outValid && !outReady;
			if (held) begin
				checkValue("inReady during stall", 512'(inReady), 0);
				heldData = outData;
			end
			if (outValid && outReady) begin
				if (expectQ.size() == 0) begin
					errors++;
					$display("output at %0t arrived with no pending input", $time);
				end else begin
					expected = expectQ.pop_front();
					accTime = acceptTimes.pop_front();
					checkValue("outData", outData, expected);
					if (checkLatency) begin
						checkValue("latency", 512'(($time - accTime) / clkPeriod),
							512'(expectLatency));
					end
					if (backToBack && got > 0) begin
						checkValue("output spacing", 512'(($time - lastRx) / clkPeriod), 1);
					end
				end
				lastRx = $time;
				got++;
				idle = 0;
			end else begin
				idle++;
				if (idle > waitLimit) begin
					abortOnTimeout("an output transfer");
				end
			end
			outReady <= stall ? nextRcvBit() : 1'b1;
		end
		outReady <= 1'b1;
	endtask

	task automatic runPhase(input int total, input bit gaps, input bit stall,
		input bit backToBack, input bit checkLatency);
		fork
			driveVectors(total, gaps);
			collectResults(total, stall, backToBack, checkLatency);
		join
		checkValue("pending results", 512'(expectQ.size()), 0);
	endtask

	initial begin
		rst = 1'b1;
		inValid = 1'b0;
		inData = '0;
		outReady = 1'b1;
		errors = 0;
		checks = 0;
		drvLfsr = 32'hdf69;
		rcvLfsr = 32'hdf69;
		// move the stall stream away from the gap stream
		for (int i = 0; i < 17; i++) begin
			rcvLfsr = lfsrStep(rcvLfsr);
		end
		loadVectors();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		checkValue("outValid after reset", 512'(outValid), 0);
		checkValue("inReady after reset", 512'(inReady), 1);

		runPhase(1, 0, 0, 0, 1);
		runPhase(numVectors, 0, 0, 1, 1);
		runPhase(3 * numVectors, 1, 0, 0, 1);
		runPhase(3 * numVectors, 1, 1, 0, 0);

		// nothing may come out once all results are taken
		for (int i = 0; i < expectLatency + 4; i++) begin
			@(posedge clk);
			checkValue("outValid when idle", 512'(outValid), 0);
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* hw/skein512Block.sv */
`timescale 1ns/1ps
// Skein-512 UBI block compression, fully unrolled Threefish-512, 56 cycle latency
// valid/ready on both sides; the whole pipeline stalls while the output is held
// one block per cycle throughput, results leave in input order
module skein512Block (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input skeinPkg::blockInT inData,
	output logic outValid,
	input logic outReady,
	output skeinPkg::stateT outData
);

	logic advance;
	// slot s feeds stage s, slot numKeyStages feeds the finish register
	skeinPkg::pipeT stageData [0:skeinPkg::numKeyStages];
	logic [0:skeinPkg::numKeyStages] stageValid;

	// move everything whenever the output slot is empty or being taken
	assign advance = !outValid || outReady;
	assign inReady = advance;

	threefishKeyExpand u_keyExpand (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.inValid(inValid),
		.inData(inData),
		.outValid(stageValid[0]),
		.outData(stageData[0])
	);

	for (genvar s = 0; s < skeinPkg::numKeyStages; s++) begin : genStage
		threefishStage #(
			.stageIndex(s)
		) u_stage (
			.clk(clk),
			.rst(rst),
			.advance(advance),
			.inValid(stageValid[s]),
			.inData(stageData[s]),
			.outValid(stageValid[s+1]),
			.outData(stageData[s+1])
		);
	end

	ubiFinish u_finish (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.inValid(stageValid[skeinPkg::numKeyStages]),
		.inData(stageData[skeinPkg::numKeyStages]),
		.outValid(outValid),
		.outData(outData)
	);

endmodule

/* hw/ubiFinish.sv */
`timescale 1ns/1ps
// last subkey injection and the UBI feed-forward XOR, one register deep
// expects key and tweak already rotated to subkey 18 by the last stage
module ubiFinish (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic inValid,
	input skeinPkg::pipeT inData,
	output logic outValid,
	output skeinPkg::stateT outData
);

	skeinPkg::stateT cipherText;
	skeinPkg::stateT chainOut;

	always_comb begin
		cipherText = skeinPkg::addSubkey(inData.state, inData.key, inData.tweak,
			skeinPkg::wordT'(skeinPkg::numKeyStages));
		// chaining value is ciphertext xor plaintext
		chainOut = cipherText ^ inData.msg;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (advance) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			outData <= chainOut;
		end
	end

endmodule

/* hw/threefishKeyExpand.sv */
`timescale 1ns/1ps
// entry register of the Threefish-512 pipeline
// extends the key with its parity word and the tweak with t0 ^ t1
module threefishKeyExpand (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic inValid,
	input skeinPkg::blockInT inData,
	output logic outValid,
	output skeinPkg::pipeT outData
);

	skeinPkg::wordT parityWord;
	skeinPkg::pipeT entry;

	always_comb begin
		parityWord = skeinPkg::keyParity;
		for (int i = 0; i < skeinPkg::numWords; i++) begin
			parityWord = parityWord ^ inData.key[i];
		end
		// message doubles as the starting state
		entry.msg = inData.msg;
		entry.state = inData.msg;
		entry.key = {inData.key, parityWord};
		entry.tweak = {inData.tweak, inData.tweak[0] ^ inData.tweak[1]};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (advance) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			outData <= entry;
		end
	end

endmodule

/* hw/threefishStage.sv */
`timescale 1ns/1ps
// one key-injection stage covering four Threefish-512 rounds in three cycles
// stageIndex must lie in 0..17; it selects the subkey and the rotation set
// key and tweak leave rotated by one word, ready for the next subkey
module threefishStage #(
	parameter int stageIndex = 0
) (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic inValid,
	input skeinPkg::pipeT inData,
	output logic outValid,
	output skeinPkg::pipeT outData
);

	skeinPkg::pipeT injected;
	skeinPkg::pipeT keyedData;
	logic keyedValid;
	skeinPkg::pipeT midData;
	logic midValid;

	always_comb begin
		injected.msg = inData.msg;
		injected.state = skeinPkg::addSubkey(inData.state, inData.key, inData.tweak,
			skeinPkg::wordT'(stageIndex));
		// next stage reads subkey stageIndex+1 from word 0 onward
		injected.key = {inData.key[1:skeinPkg::numWords], inData.key[0]};
		injected.tweak = {inData.tweak[1:2], inData.tweak[0]};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			keyedValid <= 1'b0;
		end else if (advance) begin
			keyedValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			keyedData <= injected;
		end
	end

	// rounds 4s and 4s+1
	threefishMixPair #(
		.layerBase(0),
		.oddStage(stageIndex % 2)
	) u_mixA (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.inValid(keyedValid),
		.inData(keyedData),
		.outValid(midValid),
		.outData(midData)
	);

	// rounds 4s+2 and 4s+3
	threefishMixPair #(
		.layerBase(2),
		.oddStage(stageIndex % 2)
	) u_mixB (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.inValid(midValid),
		.inData(midData),
		.outValid(outValid),
		.outData(outData)
	);

endmodule

/* hw/threefishMixPair.sv */
`timescale 1ns/1ps
// two consecutive Threefish-512 MIX layers with their permutation, one register deep
// layerBase must be 0 or 2, oddStage must be 0 or 1
// key, tweak and msg pass through unchanged to stay aligned with the state
module threefishMixPair #(
	parameter int layerBase = 0,
	parameter int oddStage = 0
) (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic inValid,
	input skeinPkg::pipeT inData,
	output logic outValid,
	output skeinPkg::pipeT outData
);

	skeinPkg::stateT mixed;

	// one MIX layer over four word pairs
	function automatic skeinPkg::stateT mixLayer(input skeinPkg::stateT s, input int layer);
		skeinPkg::stateT r;
		int a;
		int b;
		int amt;
		r = s;
		for (int p = 0; p < 4; p++) begin
			a = skeinPkg::permIndex[layer][2*p];
			b = skeinPkg::permIndex[layer][2*p+1];
			amt = skeinPkg::rotAmount[oddStage][layer][p];
			r[a] = r[a] + r[b];
			// left rotate, amounts are never zero
			r[b] = ((r[b] << amt) | (r[b] >> (skeinPkg::wordBits - amt))) ^ r[a];
		end
		return r;
	endfunction

	always_comb begin
		mixed = mixLayer(mixLayer(inData.state, layerBase), layerBase + 1);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (advance) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			outData.msg <= inData.msg;
			outData.state <= mixed;
			outData.key <= inData.key;
			outData.tweak <= inData.tweak;
		end
	end

endmodule

/* hw/skeinPkg.sv */
// Threefish-512 types, constants and tables for the Skein-512 block engine
// word 0 of every packed state, key or tweak sits in the most significant bits
// words are taken in Threefish order, so no byte reordering is done here
package skeinPkg;

	localparam int wordBits = 64;
	localparam int numWords = 8;
	localparam int numKeyStages = 18;

	// key add plus two registered mix pairs
	localparam int stageLatency = 3;
	// entry register, all key-injection stages, finish register
	localparam int pipeLatency = 1 + numKeyStages * stageLatency + 1;

	localparam logic [wordBits-1:0] keyParity = 64'h1BD11BDAA9FC1A22;

	typedef logic [wordBits-1:0] wordT;
	typedef wordT [0:numWords-1] stateT;
	// eight key words plus the parity word
	typedef wordT [0:numWords] keyT;
	// two tweak words plus their XOR
	typedef wordT [0:2] tweakT;

	typedef struct packed {
		stateT msg;
		stateT state;
		keyT key;
		tweakT tweak;
	} pipeT;

	typedef struct packed {
		stateT msg;
		stateT key;
		wordT [0:1] tweak;
	} blockInT;

	// rotation per [odd stage][layer][pair], rounds 0-3 and 4-7 of the eight-round cycle
	localparam int rotAmount [0:1][0:3][0:3] = '{
		'{
			'{46, 36, 19, 37},
			'{33, 27, 14, 42},
			'{17, 49, 36, 39},
			'{44,  9, 54, 56}
		},
		'{
			'{39, 30, 34, 24},
			'{13, 50, 10, 17},
			'{25, 29, 39, 43},
			'{ 8, 35, 56, 22}
		}
	};

	// word pairings per layer, the permutation folded into the indices
	localparam int permIndex [0:3][0:7] = '{
		'{0, 1, 2, 3, 4, 5, 6, 7},
		'{2, 1, 4, 7, 6, 5, 0, 3},
		'{4, 1, 6, 3, 0, 5, 2, 7},
		'{6, 1, 0, 7, 2, 5, 4, 3}
	};

	// subkey injection, key and tweak already rotated to the wanted subkey
	function automatic stateT addSubkey(
		input stateT s,
		input keyT k,
		input tweakT t,
		input wordT index
	);
		stateT r;
		for (int i = 0; i < numWords; i++) begin
			r[i] = s[i] + k[i];
		end
		r[5] = r[5] + t[0];
		r[6] = r[6] + t[1];
		r[7] = r[7] + index;
		return r;
	endfunction

endpackage
